/* design/div_pkg.sv */
`default_nettype none

package div_pkg;

	localparam int data_w = 32;
	localparam int tag_w = 4;
	localparam int digit_w = 4; // Quotient bits per iteration.
	localparam int num_iter = data_w / digit_w;

	typedef enum logic [1:0] {
		idle,
		iterate,
		done
	} div_state_t;

	// Request as written by the producer.
	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic [data_w-1:0] dividend;
		logic [data_w-1:0] divisor;
	} div_cmd_t;

	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic [data_w-1:0] quotient;
		logic [data_w-1:0] remainder;
	} div_res_t;

endpackage

`default_nettype wire

/* design/div_cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module div_cmd_fifo #(
	parameter int depth = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  div_pkg::div_cmd_t din,
	input  logic pop,
	output div_pkg::div_cmd_t dout,
	output logic empty,
	output logic credit
);
	import div_pkg::*;

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);
	localparam logic [ptr_w-1:0] ptr_last = ptr_w'(depth - 1);
	localparam logic [cnt_w-1:0] cnt_full = cnt_w'(depth);

	div_cmd_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;

	assign empty = (count == '0);
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			credit <= pop; // One credit back per entry freed.
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// Producer may only write while holding a credit.
	assert_no_overflow: assert property (
		@(posedge clk) disable iff (!reset)
		push |-> (count != cnt_full)
	) else $error("div_cmd_fifo: push while full");

	assert_no_underflow: assert property (
		@(posedge clk) disable iff (!reset)
		pop |-> !empty
	) else $error("div_cmd_fifo: pop while empty");

endmodule

`default_nettype wire

/* design/div_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module div_stage (
	input  logic [div_pkg::digit_w-1:0] digit,
	input  logic [div_pkg::data_w-1:0] divisor,
	input  logic [div_pkg::data_w-1:0] rem_in,
	output logic [div_pkg::data_w-1:0] rem_out,
	output logic [div_pkg::digit_w-1:0] q
);
	import div_pkg::*;

	always_comb begin : rows
		logic [data_w-1:0] rem;
		logic [data_w:0] shifted;
		logic [data_w+1:0] diff;
		rem = rem_in;
		q = '0;
		// One subtract-and-select row per quotient bit, MSB first.
		for (int i = digit_w - 1; i >= 0; i--) begin
			shifted = {rem, digit[i]}; // Keeps the bit shifted out.
			diff = {1'b0, shifted} - {2'b00, divisor};
			if (!diff[data_w+1]) begin
				rem = diff[data_w-1:0];
				q[i] = 1'b1;
			end else begin
				rem = shifted[data_w-1:0];
				q[i] = 1'b0;
			end
		end
		rem_out = rem;
	end

endmodule

`default_nettype wire

/* design/div_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module div_datapath (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  logic step,
	input  div_pkg::div_cmd_t cmd,
	output div_pkg::div_res_t res
);
	import div_pkg::*;

	logic [tag_w-1:0] tag_q;
	logic [data_w-1:0] divisor_q;
	logic [data_w-1:0] dvd_sr; // Unconsumed dividend digits.
	logic [data_w-1:0] rem_q;
	logic [data_w-1:0] quo_q;
	logic [digit_w-1:0] stage_digit;
	logic [data_w-1:0] stage_rem;
	logic [digit_w-1:0] stage_q;

	assign stage_digit = dvd_sr[data_w-1 -: digit_w];

	div_stage u_stage (
		.digit(stage_digit),
		.divisor(divisor_q),
		.rem_in(rem_q),
		.rem_out(stage_rem),
		.q(stage_q)
	);

	always_ff @(posedge clk) begin
		if (load) begin
			tag_q <= cmd.tag;
			divisor_q <= cmd.divisor;
			dvd_sr <= cmd.dividend;
		end else if (step) begin
			dvd_sr <= dvd_sr << digit_w;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rem_q <= '0;
			quo_q <= '0;
		end else if (load) begin
			rem_q <= '0;
			quo_q <= '0;
		end else if (step) begin
			rem_q <= stage_rem;
			quo_q <= {quo_q[data_w-digit_w-1:0], stage_q}; // New digit in at the bottom.
		end
	end

	assign res = '{
		tag: tag_q,
		quotient: quo_q,
		remainder: rem_q
	};

endmodule

`default_nettype wire

/* design/div_control.sv */
`timescale 1ns/1ps
`default_nettype none

module div_control #(
	parameter int res_credits = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic empty,
	output logic pop,
	output logic step,
	output logic res_valid,
	input  logic res_credit
);
	import div_pkg::*;

	localparam int cnt_w = $clog2(num_iter);
	localparam int cred_w = $clog2(res_credits + 1);
	localparam logic [cnt_w-1:0] last_iter = cnt_w'(num_iter - 1);
	localparam logic [cred_w-1:0] cred_max = cred_w'(res_credits);

	div_state_t state;
	div_state_t state_next;
	logic [cnt_w-1:0] iter_cnt;
	logic [cred_w-1:0] cred_cnt;

	// Issue needs a waiting command and a free result slot.
	assign pop = (state != iterate) && !empty && (cred_cnt != '0);
	assign step = (state == iterate);
	assign res_valid = (state == done);

	always_comb begin
		state_next = state;
		case (state)
			idle: begin
				if (pop) begin
					state_next = iterate;
				end
			end
			iterate: begin
				if (iter_cnt == last_iter) begin
					state_next = done;
				end
			end
			done: begin
				state_next = pop ? iterate : idle; // Back-to-back issue.
			end
			default: begin
				state_next = idle;
			end
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= idle;
			iter_cnt <= '0;
		end else begin
			state <= state_next;
			if (pop) begin
				iter_cnt <= '0;
			end else if (step) begin
				iter_cnt <= iter_cnt + 1'b1;
			end
		end
	end

	// Credit is taken at issue, so the result slot is reserved early.
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			cred_cnt <= cred_max;
		end else if (pop && !res_credit) begin
			cred_cnt <= cred_cnt - 1'b1;
		end else if (res_credit && !pop) begin
			cred_cnt <= cred_cnt + 1'b1;
		end
	end

	assert_cred_bound: assert property (
		@(posedge clk) disable iff (!reset)
		cred_cnt <= cred_max
	) else $error("div_control: result credits above limit");

	// Consumer only returns credits for results it received.
	assert_no_extra_credit: assert property (
		@(posedge clk) disable iff (!reset)
		res_credit |-> (cred_cnt < cred_max)
	) else $error("div_control: credit returned while counter full");

	assert_step_window: assert property (
		@(posedge clk) disable iff (!reset)
		pop |=> step [*num_iter] ##1 (res_valid && !step)
	) else $error("div_control: iteration sequence broken");

endmodule

`default_nettype wire

/* design/div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module div_unit #(
	parameter int cmd_depth = 4,
	parameter int res_credits = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic cmd_valid,
	input  div_pkg::div_cmd_t cmd,
	output logic cmd_credit,
	output logic res_valid,
	output div_pkg::div_res_t res,
	input  logic res_credit
);
	import div_pkg::*;

	div_cmd_t head;
	logic empty;
	logic pop;
	logic step;

	div_cmd_fifo #(
		.depth(cmd_depth)
	) u_cmd_fifo (
		.clk(clk),
		.reset(reset),
		.push(cmd_valid),
		.din(cmd),
		.pop(pop),
		.dout(head),
		.empty(empty),
		.credit(cmd_credit)
	);

	div_control #(
		.res_credits(res_credits)
	) u_control (
		.clk(clk),
		.reset(reset),
		.empty(empty),
		.pop(pop),
		.step(step),
		.res_valid(res_valid),
		.res_credit(res_credit)
	);

	// Head is captured on the same edge it leaves the queue.
	div_datapath u_datapath (
		.clk(clk),
		.reset(reset),
		.load(pop),
		.step(step),
		.cmd(head),
		.res(res)
	);

endmodule

`default_nettype wire

/* testbench/div_model.svh */
`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

// Expected results in command order.
div_res_t exp_q[$];

// A zero divisor never borrows, so every quotient bit is set and the
// dividend ends up shifted whole into the remainder.
function automatic div_res_t model_divide(input div_cmd_t c);
	div_res_t r;
	r.tag = c.tag;
	if (c.divisor == '0) begin
		r.quotient = '1;
		r.remainder = c.dividend;
	end else begin
		r.quotient = c.dividend / c.divisor;
		r.remainder = c.dividend % c.divisor;
	end
	return r;
endfunction

function automatic void expect_result(input div_cmd_t c);
	exp_q.push_back(model_divide(c));
endfunction

function automatic div_res_t take_expected();
	return exp_q.pop_front();
endfunction

function automatic int outstanding_results();
	return exp_q.size();
endfunction

`endif

/* testbench/div_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module div_unit_tb;
	import div_pkg::*;

	localparam int cmd_depth = 4;
	localparam int res_credits = 2;
	localparam int num_corner = 8;
	localparam int num_random = 60;
	localparam int clk_period = 100;
	localparam int total_cmds = 1 + num_corner + 2 * cmd_depth + res_credits + num_random;
	localparam int watchdog_cycles = 2 * (total_cmds * 13 + 150); // Issue interval plus gaps.

	logic clk;
	logic reset;
	logic cmd_valid;
	div_cmd_t cmd;
	logic cmd_credit;
	logic res_valid;
	div_res_t res;
	logic res_credit;

	integer seed = 32'h3111;
	int cycle;
	int value_errors;
	int protocol_errors;
	int cmd_credits; // Producer credits held.
	int sent_cmds;
	int credit_pulses;
	int results_seen;
	int held_results; // Results whose credit is not back yet.
	bit withhold;
	int last_send_cycle;
	int last_credit_cycle;
	int last_res_cycle;
	int pop_cycles[$];
	int return_delays[$];

	`include "div_model.svh"

	div_unit #(
		.cmd_depth(cmd_depth),
		.res_credits(res_credits)
	) UUT (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_credit(cmd_credit),
		.res_valid(res_valid),
		.res(res),
		.res_credit(res_credit)
	);

	initial clk = 1'b0;
	always #(clk_period / 2) clk = ~clk;

	function automatic div_cmd_t make_cmd(input logic [tag_w-1:0] tag,
			input logic [data_w-1:0] dividend, input logic [data_w-1:0] divisor);
		div_cmd_t c;
		c.tag = tag;
		c.dividend = dividend;
		c.divisor = divisor;
		return c;
	endfunction

	function automatic div_cmd_t random_command();
		int shift;
		div_cmd_t c;
		c.tag = tag_w'($random(seed));
		c.dividend = $random(seed);
		shift = $unsigned($random(seed)) % 32; // Spread divisor magnitudes.
		c.divisor = $unsigned($random(seed)) >> shift;
		return c;
	endfunction

	task automatic compare_result(input div_res_t got);
		div_res_t want;
		want = take_expected();
		if (got.tag != want.tag) begin
			$display("** Error: res.tag got %h expected %h at cycle %0d", got.tag, want.tag, cycle);
			value_errors++;
		end
		if (got.quotient != want.quotient) begin
			$display("** Error: res.quotient got %h expected %h (tag %h)",
				got.quotient, want.quotient, want.tag);
			value_errors++;
		end
		if (got.remainder != want.remainder) begin
			$display("** Error: res.remainder got %h expected %h (tag %h)",
				got.remainder, want.remainder, want.tag);
			value_errors++;
		end
	endtask

	// Outputs seen here were set by the previous rising edge.
	task automatic observe_outputs();
		int pop_cycle;
		res_credit = 1'b0;
		if (!withhold && return_delays.size() != 0) begin
			if (return_delays[0] == 0) begin
				void'(return_delays.pop_front());
				res_credit = 1'b1;
				held_results--;
			end else begin
				return_delays[0]--;
			end
		end
		if (cmd_credit) begin
			credit_pulses++;
			cmd_credits++;
			last_credit_cycle = cycle;
			pop_cycles.push_back(cycle - 1); // Pop was one cycle earlier.
			if (credit_pulses > sent_cmds) begin
				$display("cmd_credit pulsed with no command queued at cycle %0d", cycle);
				protocol_errors++;
			end
			if (cmd_credits > cmd_depth) begin
				$display("Producer credits went above the queue depth at cycle %0d", cycle);
				protocol_errors++;
			end
		end
		if (res_valid) begin
			results_seen++;
			last_res_cycle = cycle;
			if (held_results >= res_credits) begin
				$display("res_valid without a result credit at cycle %0d", cycle);
				protocol_errors++;
			end
			held_results++;
			return_delays.push_back($unsigned($random(seed)) % 7);
			if (pop_cycles.size() == 0) begin
				$display("res_valid with no matching pop at cycle %0d", cycle);
				protocol_errors++;
			end else begin
				pop_cycle = pop_cycles.pop_front();
				if (cycle != pop_cycle + num_iter + 1) begin
					$display("Result came %0d cycles after its pop instead of 9",
						cycle - pop_cycle);
					protocol_errors++;
				end
			end
			if (outstanding_results() == 0) begin
				$display("Result returned with no command outstanding at cycle %0d", cycle);
				protocol_errors++;
			end else begin
				compare_result(res);
			end
		end
	endtask

	task automatic next_cycle();
		@(negedge clk);
		cycle++;
		observe_outputs();
	endtask

	task automatic send_command(input div_cmd_t c, output int waited);
		waited = 0;
		while (cmd_credits == 0) begin
			cmd_valid = 1'b0;
			next_cycle();
			waited++;
		end
		cmd_valid = 1'b1;
		cmd = c;
		cmd_credits--;
		sent_cmds++;
		last_send_cycle = cycle;
		expect_result(c);
		next_cycle();
		cmd_valid = 1'b0;
	endtask

	task automatic wait_drained();
		while (outstanding_results() != 0 || return_delays.size() != 0) begin
			next_cycle();
		end
	endtask

	task automatic run_corners();
		div_cmd_t corners [num_corner];
		int waited;
		corners[0] = make_cmd(4'h1, 32'h1234_5678, 32'h0000_0000);
		corners[1] = make_cmd(4'h2, 32'h0000_0000, 32'h0000_0000);
		corners[2] = make_cmd(4'h3, 32'hffff_ffff, 32'h0000_0000);
		corners[3] = make_cmd(4'h4, 32'hdead_beef, 32'h0000_0001);
		corners[4] = make_cmd(4'h5, 32'h0000_0005, 32'h0000_0007);
		corners[5] = make_cmd(4'h6, 32'h8000_0001, 32'h8000_0001);
		corners[6] = make_cmd(4'h7, 32'hffff_ffff, 32'hffff_ffff);
		corners[7] = make_cmd(4'h8, 32'hffff_ffff, 32'h0000_0010);
		foreach (corners[i]) begin
			send_command(corners[i], waited);
		end
	endtask

	task automatic run_burst();
		int waited;
		for (int i = 0; i < cmd_depth; i++) begin
			send_command(random_command(), waited);
			if (waited != 0) begin
				$display("Burst command %0d had to wait for a credit", i);
				protocol_errors++;
			end
		end
	endtask

	task automatic run_backpressure();
		int waited;
		int seen_before;
		seen_before = results_seen;
		withhold = 1'b1;
		for (int i = 0; i < cmd_depth + res_credits; i++) begin
			send_command(random_command(), waited);
		end
		repeat (30) next_cycle();
		if (results_seen - seen_before != res_credits) begin
			$display("** Error: results under back-pressure got %h expected %h",
				results_seen - seen_before, res_credits);
			value_errors++;
		end
		if (cmd_credits != 0) begin
			$display("Command queue did not fill while result credits were withheld");
			protocol_errors++;
		end
		withhold = 1'b0;
		wait_drained();
	endtask

	initial begin
		int waited;
		int gap;
		reset = 1'b0;
		cmd_valid = 1'b0;
		cmd = '0;
		res_credit = 1'b0;
		withhold = 1'b0;
		cmd_credits = cmd_depth;
		repeat (3) next_cycle();
		reset = 1'b1;
		repeat (10) next_cycle(); // Quiet outputs after reset.

		send_command(make_cmd(4'ha, 32'h0000_0064, 32'h0000_0007), waited);
		wait_drained();
		if (last_credit_cycle != last_send_cycle + 2) begin
			$display("cmd_credit came %0d cycles after the write instead of 2",
				last_credit_cycle - last_send_cycle);
			protocol_errors++;
		end
		if (last_res_cycle != last_send_cycle + 10) begin
			$display("Idle result came %0d cycles after the write instead of 10",
				last_res_cycle - last_send_cycle);
			protocol_errors++;
		end

		run_corners();
		wait_drained();
		run_burst();
		wait_drained();
		run_backpressure();

		for (int i = 0; i < num_random; i++) begin
			send_command(random_command(), waited);
			gap = $unsigned($random(seed)) % 4;
			repeat (gap) next_cycle();
		end
		wait_drained();
		repeat (5) next_cycle();

		if (credit_pulses != sent_cmds) begin
			$display("** Error: cmd_credit pulses got %h expected %h", credit_pulses, sent_cmds);
			value_errors++;
		end
		if (cmd_credits != cmd_depth) begin
			$display("** Error: producer credits got %h expected %h", cmd_credits, cmd_depth);
			value_errors++;
		end
		if (pop_cycles.size() != 0) begin
			$display("Commands were popped but never produced a result");
			protocol_errors++;
		end

		$display("Checked %0d commands: %0d value errors, %0d protocol errors",
			sent_cmds, value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Run did not finish within %0d cycles", watchdog_cycles);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+testbench
design/div_pkg.sv
design/div_cmd_fifo.sv
design/div_stage.sv
design/div_datapath.sv
design/div_control.sv
design/div_unit.sv
testbench/div_unit_tb.sv

/* Bender.yml */
package:
  name: div_unit

sources:
  - files:
      - design/div_pkg.sv
      - design/div_cmd_fifo.sv
      - design/div_stage.sv
      - design/div_datapath.sv
      - design/div_control.sv
      - design/div_unit.sv

  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/div_unit_tb.sv
